// File: source/mandel_pkg.sv
/* mandelbrot explorer shared definitions
   Q4.21 fixed point, framebuffer geometry, view and iteration limits */
`default_nettype none

package mandel_pkg;

    localparam int FP_WIDTH = 25;  // signed fixed-point word
    localparam int FP_FRAC  = 21;  // fractional bits, 4 integer bits remain
    localparam int ITER_MAX = 63;  // iteration limit
    localparam int CIDXW    = 8;   // colour index width

    localparam int FB_WIDTH  = 32;  // framebuffer width in pixels
    localparam int FB_HEIGHT = 18;  // framebuffer height in pixels
    localparam int FB_PIXELS = 576;
    localparam int FB_ADDRW  = 10;
    localparam int CORDW     = 6;   // unsigned pixel coordinate

    // view window after reset
    localparam logic signed [FP_WIDTH-1:0] X_START  = -25'sd5242880;  // -2.5
    localparam logic signed [FP_WIDTH-1:0] Y_START  = -25'sd2359296;  // -1.125
    localparam logic signed [FP_WIDTH-1:0] STEP_MAX = 25'sd262144;    // 1/8, also reset step

    typedef enum logic [1:0] {
        MODE_HORIZONTAL = 2'd0,
        MODE_VERTICAL   = 2'd1,
        MODE_ZOOM       = 2'd2
    } view_mode_t;

endpackage

`default_nettype wire

// File: source/mandel_if.sv
/* stage-to-stage links of the render pipeline
   point_if carries scanner points to the engine, result_if engine results to the writer */
`default_nettype none
`timescale 1ns/1ps

interface point_if import mandel_pkg::*; ();

    logic                       strobe;  // one cycle, only while idle
    logic                       idle;    // engine ready for a point
    logic signed [FP_WIDTH-1:0] cr;
    logic signed [FP_WIDTH-1:0] ci;
    logic [CORDW-1:0]           px;
    logic [CORDW-1:0]           py;

    modport scan (output strobe, cr, ci, px, py, input idle);
    modport engine (input strobe, cr, ci, px, py, output idle);

endinterface

interface result_if import mandel_pkg::*; ();

    logic             strobe;  // one pulse per finished pixel
    logic [CORDW-1:0] px;
    logic [CORDW-1:0] py;
    logic [CIDXW-1:0] cidx;

    // no back-pressure, the writer always accepts
    modport engine (output strobe, px, py, cidx);
    modport writer (input strobe, px, py, cidx);

endinterface

`default_nettype wire

// File: source/view_control.sv
/* view control: mode FSM, pan and zoom of the view window with a step limit check,
   and the render start pulse */
`default_nettype none
`timescale 1ns/1ps

module view_control import mandel_pkg::*; (
    input  wire logic                    clk_sys,
    input  wire logic                    rst_sys,
    input  wire logic                    btn_mode,
    input  wire logic                    btn_up,
    input  wire logic                    btn_dn,
    input  wire logic                    render_busy,
    output logic signed [FP_WIDTH-1:0]   x_start,
    output logic signed [FP_WIDTH-1:0]   y_start,
    output logic signed [FP_WIDTH-1:0]   step,
    output logic                         start,
    output view_mode_t                   view_mode
);

    logic                       pending;     // change waiting for commit
    logic                       render_req;  // committed, start goes out next
    logic                       accept;
    logic                       step_ok;
    logic signed [FP_WIDTH-1:0] x_calc, y_calc, step_calc;
    logic signed [FP_WIDTH-1:0] x_next, y_next, step_next;

    // buttons only count when nothing is in progress
    assign accept  = !pending && !render_req && !start && !render_busy;
    assign step_ok = (step_next != '0) && (step_next <= STEP_MAX);

    // candidate window, up wins over down
    always_comb begin
        x_calc    = x_start;
        y_calc    = y_start;
        step_calc = step;
        case (view_mode)
            MODE_HORIZONTAL: x_calc = btn_up ? x_start - (step <<< 2) : x_start + (step <<< 2);
            MODE_VERTICAL:   y_calc = btn_up ? y_start - (step <<< 2) : y_start + (step <<< 2);
            MODE_ZOOM: begin
                if (btn_up) begin  // zoom in around the centre
                    x_calc    = x_start + (step <<< 3);
                    y_calc    = y_start + (step <<< 2) + (step >>> 1);
                    step_calc = step >>> 1;
                end else begin     // zoom out
                    x_calc    = x_start - (step <<< 4);
                    y_calc    = y_start - (step <<< 3) - step;
                    step_calc = step <<< 1;
                end
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk_sys) begin
        if (rst_sys) begin
            view_mode  <= MODE_HORIZONTAL;
            x_start    <= X_START;
            y_start    <= Y_START;
            step       <= STEP_MAX;
            pending    <= 1'b0;
            render_req <= 1'b1;  // first frame without any button
            start      <= 1'b0;
        end else begin
            start      <= render_req;
            render_req <= 1'b0;
            if (accept && btn_mode) begin
                case (view_mode)
                    MODE_HORIZONTAL: view_mode <= MODE_VERTICAL;
                    MODE_VERTICAL:   view_mode <= MODE_ZOOM;
                    default:         view_mode <= MODE_HORIZONTAL;
                endcase
            end
            if (accept && (btn_up || btn_dn)) begin
                pending   <= 1'b1;
                x_next    <= x_calc;
                y_next    <= y_calc;
                step_next <= step_calc;
            end
            if (pending) begin
                pending <= 1'b0;
                if (step_ok) begin  // out of range drops the whole change
                    x_start    <= x_next;
                    y_start    <= y_next;
                    step       <= step_next;
                    render_req <= 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: source/point_scan.sv
/* point scan: walks the framebuffer row by row, forms c for each pixel
   and holds render_busy until the last pixel is written */
`default_nettype none
`timescale 1ns/1ps

module point_scan import mandel_pkg::*; (
    input  wire logic                  clk_sys,
    input  wire logic                  rst_sys,
    input  wire logic                  start,
    input  wire logic signed [FP_WIDTH-1:0] x_start,
    input  wire logic signed [FP_WIDTH-1:0] y_start,
    input  wire logic signed [FP_WIDTH-1:0] step,
    point_if.scan                      pt,
    output logic                       render_busy,
    input  wire logic                  last_write
);

    logic scanning;  // points left to hand out
    logic last_col;
    logic last_row;

    assign last_col  = (pt.px == CORDW'(FB_WIDTH - 1));
    assign last_row  = (pt.py == CORDW'(FB_HEIGHT - 1));
    assign pt.strobe = scanning && pt.idle;  // issue as soon as the engine is free

    always_ff @(posedge clk_sys) begin
        if (rst_sys) begin
            scanning    <= 1'b0;
            render_busy <= 1'b0;
        end else if (start) begin
            scanning    <= 1'b1;
            render_busy <= 1'b1;
        end else begin
            if (pt.strobe && last_col && last_row) begin
                scanning <= 1'b0;
            end
            if (last_write) begin
                render_busy <= 1'b0;
            end
        end
    end

    // coordinates advance after every strobe
    always_ff @(posedge clk_sys) begin
        if (start) begin
            pt.px <= '0;
            pt.py <= '0;
            pt.cr <= x_start;
            pt.ci <= y_start;
        end else if (pt.strobe) begin
            if (last_col) begin  // wrap to next row
                pt.px <= '0;
                pt.py <= pt.py + 1'b1;
                pt.cr <= x_start;
                pt.ci <= pt.ci + step;
            end else begin
                pt.px <= pt.px + 1'b1;
                pt.cr <= pt.cr + step;
            end
        end
    end

endmodule

`default_nettype wire

// File: source/escape_iterate.sv
/* escape iteration engine: z <= z*z + c in fixed point, one step per clock,
   reports the iteration count at escape or 0 at the limit */
`default_nettype none
`timescale 1ns/1ps

module escape_iterate import mandel_pkg::*; (
    input  wire logic  clk_sys,
    input  wire logic  rst_sys,
    point_if.engine    pt,
    result_if.engine   res
);

    logic signed [FP_WIDTH-1:0]   cr, ci;
    logic signed [FP_WIDTH-1:0]   zr, zi;
    logic signed [2*FP_WIDTH-1:0] zr2, zi2, zrzi;  // products scaled back to Q.21
    logic signed [2*FP_WIDTH-1:0] mag;
    logic [CIDXW-1:0]             n;
    logic                         escaped;
    logic                         at_limit;

    // full products, arithmetic shift truncates toward minus infinity
    always_comb begin
        zr2  = (zr * zr) >>> FP_FRAC;
        zi2  = (zi * zi) >>> FP_FRAC;
        zrzi = (zr * zi) >>> FP_FRAC;
        mag  = zr2 + zi2;
    end

    assign escaped  = mag > (2*FP_WIDTH)'(4 <<< FP_FRAC);  // |z|^2 > 4.0
    assign at_limit = (n == CIDXW'(ITER_MAX));

    always_ff @(posedge clk_sys) begin
        if (rst_sys) begin
            pt.idle    <= 1'b1;
            res.strobe <= 1'b0;
        end else begin
            res.strobe <= 1'b0;
            if (pt.idle) begin
                if (pt.strobe) begin
                    pt.idle <= 1'b0;
                end
            end else if (escaped || at_limit) begin
                pt.idle    <= 1'b1;
                res.strobe <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_sys) begin
        if (pt.idle && pt.strobe) begin  // capture new point
            cr     <= pt.cr;
            ci     <= pt.ci;
            zr     <= '0;
            zi     <= '0;
            n      <= '0;
            res.px <= pt.px;
            res.py <= pt.py;
        end else if (!pt.idle) begin
            if (escaped) begin
                res.cidx <= n;
            end else if (at_limit) begin
                res.cidx <= '0;  // inside the set
            end else begin
                // new z is cut to FP_WIDTH bits
                zr <= FP_WIDTH'(zr2 - zi2 + cr);
                zi <= FP_WIDTH'((zrzi <<< 1) + ci);
                n  <= n + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: source/fb_write.sv
/* framebuffer writer: two-stage address calculation, colour index and
   write enable delayed to match, flag for the last pixel of a frame */
`default_nettype none
`timescale 1ns/1ps

module fb_write import mandel_pkg::*; (
    input  wire logic          clk_sys,
    input  wire logic          rst_sys,
    result_if.writer           res,
    output logic [FB_ADDRW-1:0] fb_addr,
    output logic [CIDXW-1:0]   fb_cidx,
    output logic               fb_we,
    output logic               last_write
);

    logic [FB_ADDRW-1:0] row_base;  // py * FB_WIDTH
    logic [CORDW-1:0]    col;
    logic [CIDXW-1:0]    cidx_d;
    logic                we_d;
    logic [FB_ADDRW-1:0] addr_sum;

    assign addr_sum = row_base + FB_ADDRW'(col);

    always_ff @(posedge clk_sys) begin
        row_base <= FB_ADDRW'(res.py * FB_WIDTH);  // stage one
        col      <= res.px;
        cidx_d   <= res.cidx;
        fb_addr  <= addr_sum;                      // stage two
        fb_cidx  <= cidx_d;
    end

    always_ff @(posedge clk_sys) begin
        if (rst_sys) begin
            we_d       <= 1'b0;
            fb_we      <= 1'b0;
            last_write <= 1'b0;
        end else begin
            we_d       <= res.strobe;
            fb_we      <= we_d;
            last_write <= we_d && (addr_sum == FB_ADDRW'(FB_PIXELS - 1));
        end
    end

endmodule

`default_nettype wire

// File: source/mandel_top.sv
/* mandelbrot explorer render pipeline: view control, point scan,
   escape iteration and framebuffer write */
`default_nettype none
`timescale 1ns/1ps

module mandel_top import mandel_pkg::*; (
    input  wire logic           clk_sys,
    input  wire logic           rst_sys,
    input  wire logic           btn_mode,  // clean single-cycle pulses
    input  wire logic           btn_up,
    input  wire logic           btn_dn,
    output logic [FB_ADDRW-1:0] fb_addr,
    output logic [CIDXW-1:0]    fb_cidx,
    output logic                fb_we,
    output logic                render_busy,
    output view_mode_t          view_mode
);

    logic signed [FP_WIDTH-1:0] x_start;
    logic signed [FP_WIDTH-1:0] y_start;
    logic signed [FP_WIDTH-1:0] step;
    logic                       start;
    logic                       last_write;

    point_if  point_bus ();
    result_if result_bus ();

    view_control u_view_control (
        .clk_sys     (clk_sys),
        .rst_sys     (rst_sys),
        .btn_mode    (btn_mode),
        .btn_up      (btn_up),
        .btn_dn      (btn_dn),
        .render_busy (render_busy),
        .x_start     (x_start),
        .y_start     (y_start),
        .step        (step),
        .start       (start),
        .view_mode   (view_mode)
    );

    point_scan u_point_scan (
        .clk_sys     (clk_sys),
        .rst_sys     (rst_sys),
        .start       (start),
        .x_start     (x_start),
        .y_start     (y_start),
        .step        (step),
        .pt          (point_bus.scan),
        .render_busy (render_busy),
        .last_write  (last_write)
    );

    escape_iterate u_escape_iterate (
        .clk_sys (clk_sys),
        .rst_sys (rst_sys),
        .pt      (point_bus.engine),
        .res     (result_bus.engine)
    );

    fb_write u_fb_write (
        .clk_sys    (clk_sys),
        .rst_sys    (rst_sys),
        .res        (result_bus.writer),
        .fb_addr    (fb_addr),
        .fb_cidx    (fb_cidx),
        .fb_we      (fb_we),
        .last_write (last_write)
    );

endmodule

`default_nettype wire

// File: test/mandel_assertions.sv
/* bound checks on the framebuffer write port and the view mode
   of the mandelbrot render pipeline */
`default_nettype none
`timescale 1ns/1ps

module mandel_assertions import mandel_pkg::*; (
    input wire logic                clk_sys,
    input wire logic                rst_sys,
    input wire logic                fb_we,
    input wire logic [FB_ADDRW-1:0] fb_addr,
    input wire logic                render_busy,
    input wire logic [1:0]          view_mode
);

    int failures = 0;  // read by the testbench at the end of the run

    addr_in_frame: assert property (@(posedge clk_sys) disable iff (rst_sys)
        fb_we |-> (fb_addr < FB_ADDRW'(FB_PIXELS)))
        else begin
            failures++;
            $error("framebuffer write to address %0d outside the frame", fb_addr);
        end

    // first cycle of reset still carries the power-up value
    quiet_in_reset: assert property (@(posedge clk_sys)
        (rst_sys && $past(rst_sys)) |-> !fb_we)
        else begin
            failures++;
            $error("framebuffer write during reset");
        end

    mode_legal: assert property (@(posedge clk_sys) disable iff (rst_sys)
        view_mode != 2'd3)
        else begin
            failures++;
            $error("view mode took the unused encoding");
        end

    write_in_render: assert property (@(posedge clk_sys) disable iff (rst_sys)
        fb_we |-> render_busy)
        else begin
            failures++;
            $error("framebuffer write outside a render");
        end

endmodule

bind mandel_top mandel_assertions u_assertions (
    .clk_sys     (clk_sys),
    .rst_sys     (rst_sys),
    .fb_we       (fb_we),
    .fb_addr     (fb_addr),
    .render_busy (render_busy),
    .view_mode   (view_mode)
);

`default_nettype wire

// File: test/mandel_tb.sv
/* testbench for the mandelbrot render pipeline
   drives button pulses, models the view window and checks every framebuffer write */
`default_nettype none
`timescale 1ns/1ps

module mandel_tb import mandel_pkg::*; ();

    logic                clk_sys;
    logic                rst_sys;
    logic                btn_mode;
    logic                btn_up;
    logic                btn_dn;
    logic [FB_ADDRW-1:0] fb_addr;
    logic [CIDXW-1:0]    fb_cidx;
    logic                fb_we;
    logic                render_busy;
    view_mode_t          view_mode;

    view_mode_t m_mode;  // model of the view window in exact Q.21 values
    longint     m_x;
    longint     m_y;
    longint     m_step;
    bit         written [FB_PIXELS];
    int         write_count;

    mandel_top u_dut (
        .clk_sys     (clk_sys),
        .rst_sys     (rst_sys),
        .btn_mode    (btn_mode),
        .btn_up      (btn_up),
        .btn_dn      (btn_dn),
        .fb_addr     (fb_addr),
        .fb_cidx     (fb_cidx),
        .fb_we       (fb_we),
        .render_busy (render_busy),
        .view_mode   (view_mode)
    );

    initial begin
        clk_sys = 1'b0;
        forever #50 clk_sys = ~clk_sys;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Something failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string what, input int got, input int exp);
        if (got != exp) begin
            abort_run($sformatf("CHECK FAILED at %0t: %s is %0d, expected %0d",
                                $time, what, got, exp));
        end
    endtask

    // cut to the fixed-point word as the hardware registers do
    function automatic longint wrap_fp(input longint v);
        logic signed [FP_WIDTH-1:0] word;
        word = v[FP_WIDTH-1:0];
        return longint'(word);
    endfunction

    function automatic int ref_iter(input longint cr, input longint ci);
        longint zr, zi, zr2, zi2, zrzi;
        int     n;
        zr = 0;
        zi = 0;
        for (n = 0; n <= ITER_MAX; n++) begin
            zr2  = (zr * zr) >>> FP_FRAC;
            zi2  = (zi * zi) >>> FP_FRAC;
            zrzi = (zr * zi) >>> FP_FRAC;
            if (zr2 + zi2 > (longint'(4) <<< FP_FRAC)) begin
                return n;  // escaped
            end
            if (n == ITER_MAX) begin
                return 0;  // inside the set
            end
            zr = wrap_fp(zr2 - zi2 + cr);
            zi = wrap_fp((zrzi <<< 1) + ci);
        end
        return 0;
    endfunction

    function automatic int expected_cidx(input int addr);
        longint cr;
        longint ci;
        cr = wrap_fp(m_x + longint'(addr % FB_WIDTH) * m_step);
        ci = wrap_fp(m_y + longint'(addr / FB_WIDTH) * m_step);
        return ref_iter(cr, ci);
    endfunction

    // which selects 0 mode, 1 up, 2 down
    task automatic apply_press(input int which);
        longint nx, ny, ns;
        nx = m_x;
        ny = m_y;
        ns = m_step;
        if (which == 0) begin
            case (m_mode)
                MODE_HORIZONTAL: m_mode = MODE_VERTICAL;
                MODE_VERTICAL:   m_mode = MODE_ZOOM;
                default:         m_mode = MODE_HORIZONTAL;
            endcase
        end else begin
            case (m_mode)
                MODE_HORIZONTAL: nx = (which == 1) ? m_x - 4 * m_step : m_x + 4 * m_step;
                MODE_VERTICAL:   ny = (which == 1) ? m_y - 4 * m_step : m_y + 4 * m_step;
                default: begin
                    if (which == 1) begin  // zoom in around a fixed centre
                        nx = m_x + 8 * m_step;
                        ny = m_y + 4 * m_step + m_step / 2;
                        ns = m_step / 2;
                    end else begin
                        nx = m_x - 16 * m_step;
                        ny = m_y - 9 * m_step;
                        ns = 2 * m_step;
                    end
                end
            endcase
            if (ns != 0 && ns <= longint'(STEP_MAX)) begin
                m_x    = nx;
                m_y    = ny;
                m_step = ns;
            end
        end
    endtask

    task automatic press(input int which);
        logic busy;
        @(posedge clk_sys);
        case (which)
            0:       btn_mode <= 1'b1;
            1:       btn_up <= 1'b1;
            default: btn_dn <= 1'b1;
        endcase
        @(negedge clk_sys);
        busy = render_busy;  // level the DUT sees on the next edge
        @(posedge clk_sys);
        btn_mode <= 1'b0;
        btn_up   <= 1'b0;
        btn_dn   <= 1'b0;
        if (!busy) begin
            apply_press(which);
        end
    endtask

    task automatic wait_busy(input logic level, input int limit);
        int cycles;
        cycles = 0;
        @(negedge clk_sys);
        while (render_busy !== level) begin
            cycles++;
            if (cycles > limit) begin
                abort_run($sformatf("timeout waiting for render_busy to become %0b", level));
            end
            @(negedge clk_sys);
        end
    endtask

    task automatic check_mode();
        @(negedge clk_sys);
        check_value("view_mode", int'(view_mode), int'(m_mode));
    endtask

    task automatic clear_frame();
        foreach (written[i]) begin
            written[i] = 1'b0;
        end
        write_count = 0;
    endtask

    task automatic check_frame();
        check_value("pixels written in the frame", write_count, FB_PIXELS);
        foreach (written[i]) begin
            check_value($sformatf("write flag of pixel %0d", i), int'(written[i]), 1);
        end
    endtask

    task automatic render_after(input int which);
        clear_frame();
        press(which);
        wait_busy(1'b1, 20);
        wait_busy(1'b0, 100000);
        check_frame();
    endtask

    // every write is checked against the model window
    always @(negedge clk_sys) begin
        if (u_dut.u_assertions.failures != 0) begin
            abort_run("a bound assertion on the write port or view mode failed");
        end
        if (!rst_sys && fb_we) begin
            if (written[fb_addr]) begin
                abort_run($sformatf("pixel %0d was written twice in one frame", fb_addr));
            end
            written[fb_addr] = 1'b1;
            write_count      = write_count + 1;
            check_value($sformatf("colour index of pixel %0d", fb_addr),
                        int'(fb_cidx), expected_cidx(int'(fb_addr)));
        end
    end

    initial begin
        rst_sys  = 1'b1;
        btn_mode = 1'b0;
        btn_up   = 1'b0;
        btn_dn   = 1'b0;
        m_mode   = MODE_HORIZONTAL;
        m_x      = longint'(X_START);
        m_y      = longint'(Y_START);
        m_step   = longint'(STEP_MAX);
        clear_frame();
        repeat (8) @(posedge clk_sys);
        rst_sys <= 1'b0;
        @(negedge clk_sys);
        check_value("fb_we after reset", int'(fb_we), 0);
        check_value("render_busy after reset", int'(render_busy), 0);
        check_value("view_mode after reset", int'(view_mode), int'(MODE_HORIZONTAL));

        wait_busy(1'b1, 20);  // first frame needs no button
        wait_busy(1'b0, 100000);
        check_frame();

        render_after(1);  // pan left then right
        render_after(2);
        press(0);
        check_mode();
        render_after(1);  // pan up
        press(0);
        check_mode();
        render_after(1);  // zoom in twice and out twice back to the widest step
        render_after(1);
        render_after(2);
        render_after(2);

        clear_frame();
        press(2);  // step would exceed the limit
        repeat (10) begin
            @(negedge clk_sys);
            check_value("render_busy after rejected zoom", int'(render_busy), 0);
        end
        check_value("writes after rejected zoom", write_count, 0);
        press(0);
        check_mode();

        clear_frame();
        press(2);
        wait_busy(1'b1, 20);
        press(0);  // all ignored while busy
        press(1);
        press(2);
        check_mode();
        wait_busy(1'b0, 100000);
        check_frame();
        check_mode();

        if (u_dut.u_assertions.failures == 0) begin
            $display("Everything OK");
            $finish;
        end else begin
            abort_run("a bound assertion on the write port or view mode failed");
        end
    end

endmodule

`default_nettype wire

// File: verilog.f
source/mandel_pkg.sv
source/mandel_if.sv
source/view_control.sv
source/point_scan.sv
source/escape_iterate.sv
source/fb_write.sv
source/mandel_top.sv
test/mandel_assertions.sv
test/mandel_tb.sv

// File: Makefile
TOP = mandel_tb

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f verilog.f
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "Everything OK"

clean:
	rm -rf obj_dir

.PHONY: sim clean
